// File: logic/arb_pkg.sv
package arb_pkg;

  localparam int NUM_PORTS = 4;
  localparam int ADDR_W    = 4;
  localparam int DATA_W    = 8;
  localparam int MEM_DEPTH = 16;

  typedef logic [NUM_PORTS-1:0]         port_vec_t; // One bit per requester
  typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;
  typedef logic [2:0]                   arb_mode_t;
  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [DATA_W-1:0]            data_t;

  localparam arb_mode_t MODE_P0   = 3'd0;
  localparam arb_mode_t MODE_P1   = 3'd1;
  localparam arb_mode_t MODE_P2   = 3'd2;
  localparam arb_mode_t MODE_P3   = 3'd3;
  localparam arb_mode_t MODE_RR   = 3'd4;
  localparam arb_mode_t MODE_RAND = 3'd5;

  // Index of the set bit, 0 for an empty vector
  function automatic port_idx_t onehot_to_idx(port_vec_t onehot);
    port_idx_t idx;
    idx = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (onehot[i]) begin
        idx = port_idx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

// File: logic/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if import arb_pkg::*; ();

  logic  en;    // One-cycle access strobe
  logic  we;
  addr_t addr;
  data_t wdata;
  data_t rdata; // Registered read result

  modport master (
    output en, we, addr, wdata
  );

  modport slave (
    input  en, we, addr, wdata,
    output rdata
  );

endinterface

// File: logic/pn_seq_gen.sv
`timescale 1ns/1ps

module pn_seq_gen import arb_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output port_idx_t rand_sel
);

  logic [2:0] stage; // stage[0] is the newest bit
  logic       feedback;

  // Taps on stages 1 and 3, maximal length of 7
  assign feedback = stage[0] ^ stage[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage <= 3'b001;
    end else begin
      stage <= {stage[1:0], feedback}; // Shifts every cycle
    end
  end

  assign rand_sel = stage[2:1]; // Two oldest stages

endmodule

// File: logic/grant_arbiter.sv
`timescale 1ns/1ps

module grant_arbiter import arb_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  port_vec_t req,
  input  arb_mode_t mode,
  input  logic      decide,      // Arbitration strobe
  input  logic      release_gnt, // Transaction closed
  input  port_idx_t rand_sel,
  output port_vec_t gnt
);

  port_vec_t fixed_cand [NUM_PORTS]; // Entry n is the Pn winner
  port_vec_t rr_cand;
  port_vec_t rand_cand;
  port_vec_t next_gnt;
  port_idx_t rr_last;                // Previous winner

  // Favoured port first, then the rest in ascending index order
  function automatic port_vec_t fixed_pick(port_vec_t r, port_idx_t first);
    port_vec_t pick;
    pick = '0;
    if (r[first]) begin
      pick[first] = 1'b1;
    end else begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (r[i] && (pick == '0)) begin
          pick[i] = 1'b1;
        end
      end
    end
    return pick;
  endfunction

  // Scan starts at the port after the last winner
  function automatic port_vec_t rr_pick(port_vec_t r, port_idx_t last);
    port_vec_t pick;
    port_idx_t idx;
    pick = '0;
    idx  = last;
    for (int k = 0; k < NUM_PORTS; k++) begin
      idx = idx + port_idx_t'(1); // Wraps from the top port to 0
      if (r[idx] && (pick == '0)) begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      fixed_cand[p] = fixed_pick(req, port_idx_t'(p));
    end
  end

  assign rr_cand = rr_pick(req, rr_last);

  // LFSR picks which fixed scheme applies this round
  assign rand_cand = fixed_cand[rand_sel];

  always_comb begin
    case (mode)
      MODE_P0:   next_gnt = fixed_cand[0];
      MODE_P1:   next_gnt = fixed_cand[1];
      MODE_P2:   next_gnt = fixed_cand[2];
      MODE_P3:   next_gnt = fixed_cand[3];
      MODE_RR:   next_gnt = rr_cand;
      MODE_RAND: next_gnt = rand_cand;
      default:   next_gnt = '0; // Unused codes grant nobody
    endcase
  end

  // Grant is held from decide until release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt <= '0;
    end else if (release_gnt) begin
      gnt <= '0;
    end else if (decide) begin
      gnt <= next_gnt;
    end
  end

  // History follows every real grant, in any mode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_last <= '0; // First round-robin order is 1, 2, 3, 0
    end else if (decide && (next_gnt != '0)) begin
      rr_last <= onehot_to_idx(next_gnt);
    end
  end

endmodule

// File: logic/access_sequencer.sv
`timescale 1ns/1ps

module access_sequencer import arb_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  port_vec_t             req,
  input  port_vec_t             we,
  input  addr_t [NUM_PORTS-1:0] addr,
  input  data_t [NUM_PORTS-1:0] wdata,
  input  port_vec_t             gnt,
  output logic                  decide,
  output logic                  release_gnt,
  output port_vec_t             ack,
  mem_bus_if.master             bus
);

  typedef enum logic [2:0] {
    IDLE,
    DECIDE,  // Arbiter loads gnt at the end of this cycle
    ACCESS,  // Memory strobe
    ACK,     // Waiting for the winner to drop req
    CLOSE    // Gap before the next round
  } seq_state_t;

  seq_state_t state;
  seq_state_t state_nxt;
  port_idx_t  win;       // Index of the granted requester
  logic       win_req;
  logic       have_gnt;

  assign win      = onehot_to_idx(gnt);
  assign win_req  = req[win];
  assign have_gnt = (gnt != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (req != '0) begin
          state_nxt = DECIDE;
        end
      end
      DECIDE: state_nxt = ACCESS;
      ACCESS: begin
        // Empty grant means nobody was picked, try again
        state_nxt = have_gnt ? ACK : IDLE;
      end
      ACK: begin
        if (!win_req) begin
          state_nxt = CLOSE;
        end
      end
      CLOSE:   state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  assign decide = (state == DECIDE);

  // Drops gnt on the same edge that ends ack
  assign release_gnt = (state == ACK) && !win_req;

  // Only the granted port sees ack
  assign ack = (state == ACK) ? gnt : '0;

  // Winner's fields onto the memory bus
  assign bus.en    = (state == ACCESS) && have_gnt;
  assign bus.we    = we[win];
  assign bus.addr  = addr[win];
  assign bus.wdata = wdata[win];

endmodule

// File: logic/shared_mem.sv
`timescale 1ns/1ps

module shared_mem import arb_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  mem_bus_if.slave bus
);

  data_t mem [MEM_DEPTH];

  // Storage array
  always_ff @(posedge clk) begin
    if (bus.en && bus.we) begin
      mem[bus.addr] <= bus.wdata;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.rdata <= '0;
    end else if (bus.en && !bus.we) begin
      bus.rdata <= mem[bus.addr];
    end
  end

endmodule

// File: logic/arb_top.sv
`timescale 1ns/1ps

module arb_top import arb_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  port_vec_t             req,
  input  port_vec_t             we,      // High for write
  input  addr_t [NUM_PORTS-1:0] addr,
  input  data_t [NUM_PORTS-1:0] wdata,
  input  arb_mode_t             arb_mode,
  output port_vec_t             ack,
  output data_t                 rdata,   // Valid while ack is high on a read
  output port_vec_t             gnt
);

  port_idx_t rand_sel;
  logic      decide;
  logic      release_gnt;

  mem_bus_if mem_bus ();

  pn_seq_gen pn_seq_gen_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_sel (rand_sel)
  );

  grant_arbiter grant_arbiter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .mode        (arb_mode),
    .decide      (decide),
    .release_gnt (release_gnt),
    .rand_sel    (rand_sel),
    .gnt         (gnt)
  );

  access_sequencer access_sequencer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .we          (we),
    .addr        (addr),
    .wdata       (wdata),
    .gnt         (gnt),
    .decide      (decide),
    .release_gnt (release_gnt),
    .ack         (ack),
    .bus         (mem_bus.master)
  );

  shared_mem shared_mem_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (mem_bus.slave)
  );

  assign rdata = mem_bus.rdata;

endmodule

// File: tests/arb_ref.svh
// Error counters, shared by all checks
int grant_errs = 0;
int data_errs  = 0;
int proto_errs = 0;

data_t mem_model [MEM_DEPTH] = '{default: '0}; // Contents as the requesters wrote them

// Expected winner of one round, sel is the random scheme to apply
function automatic port_vec_t next_grant(port_vec_t r, arb_mode_t mode, port_idx_t last,
                                         port_idx_t sel);
  port_vec_t g;
  port_vec_t probe;
  int        first;
  g = '0;
  if (mode == MODE_RR) begin
    // Start right after the previous winner
    for (int k = 1; k <= NUM_PORTS; k++) begin
      probe = port_vec_t'(1) << ((int'(last) + k) % NUM_PORTS);
      if (g == '0 && (r & probe) != '0) begin
        g = probe;
      end
    end
  end else if (mode <= MODE_RAND) begin
    first = (mode == MODE_RAND) ? int'(sel) : int'(mode);
    probe = port_vec_t'(1) << first;
    if ((r & probe) != '0) begin
      g = probe;                     // Favoured port wins outright
    end else begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        probe = port_vec_t'(1) << i;
        if (g == '0 && (r & probe) != '0) begin
          g = probe;
        end
      end
    end
  end
  return g; // Codes 6 and 7 stay empty
endfunction

function automatic port_idx_t port_of(port_vec_t g);
  port_idx_t idx;
  idx = '0;
  for (int i = 0; i < NUM_PORTS; i++) begin
    if ((g & (port_vec_t'(1) << i)) != '0) begin
      idx = port_idx_t'(i);
    end
  end
  return idx;
endfunction

task automatic check_grant(input port_vec_t got, input port_vec_t exp, input string what);
  if (got !== exp) begin
    $display("ERROR @ %0t: %s is %b, expected %b", $time, what, got, exp);
    grant_errs++;
  end
endtask

task automatic check_data(input data_t got, input data_t exp, input string what);
  if (got !== exp) begin
    $display("ERROR @ %0t: %s is %h, expected %h", $time, what, got, exp);
    data_errs++;
  end
endtask

task automatic flag_protocol(input string what);
  $display("ERROR @ %0t: %s", $time, what);
  proto_errs++;
endtask

// File: tests/arb_tb.sv
`timescale 1ns/1ps

module arb_tb import arb_pkg::*; ();

  localparam int TXN_BUDGET     = 400;
  localparam int CYCLES_PER_TXN = 20;

  logic                  clk = 1'b0;
  logic                  rst_n;
  port_vec_t             req;
  port_vec_t             we;
  addr_t [NUM_PORTS-1:0] addr;
  data_t [NUM_PORTS-1:0] wdata;
  arb_mode_t             arb_mode;
  port_vec_t             ack;
  data_t                 rdata;
  port_vec_t             gnt;

  int        seed = 83;
  logic      stop_traffic;
  int        round_cnt = 0;
  port_vec_t win_log [$];   // Every grant in order

  // Values from the previous falling edge
  port_vec_t prev_req;
  port_vec_t prev_ack;
  port_vec_t prev_gnt;
  arb_mode_t prev_mode;
  port_idx_t rr_hist;       // Last winner as the reference sees it

  `include "arb_ref.svh"

  arb_top arb_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .we       (we),
    .addr     (addr),
    .wdata    (wdata),
    .arb_mode (arb_mode),
    .ack      (ack),
    .rdata    (rdata),
    .gnt      (gnt)
  );

  always #4 clk = ~clk;

  // One four-phase transaction on port p
  task automatic do_txn(input port_idx_t p, input logic w, input addr_t a, input data_t d,
                        input int hold, input bit check_lat);
    int lat;
    @(posedge clk);
    req[p]   <= 1'b1;
    we[p]    <= w;
    addr[p]  <= a;
    wdata[p] <= d;
    lat = 0;
    @(negedge clk);
    while (!ack[p]) begin
      @(negedge clk);
      lat++;
    end
    if (check_lat && lat != 3) begin
      flag_protocol($sformatf("ack rose %0d cycles after req, expected 3", lat));
    end
    repeat (hold) @(posedge clk); // Back-pressure
    @(posedge clk);
    req[p] <= 1'b0;
    @(negedge clk);
    while (ack[p]) begin
      @(negedge clk);
    end
  endtask

  task automatic drive_port(input port_idx_t p, input int count, input int max_gap,
                            input int max_hold);
    logic [31:0] rnd;
    int          gap;
    for (int n = 0; n < count && !stop_traffic; n++) begin
      rnd = $random(seed);
      gap = int'(rnd[15:8]) % (max_gap + 1);
      repeat (gap) @(posedge clk);
      do_txn(p, rnd[0], rnd[7:4], rnd[31:24], int'(rnd[23:16]) % (max_hold + 1), 1'b0);
    end
  endtask

  // All four ports at once and optionally stopped after some rounds
  task automatic run_traffic(input int count, input int max_gap, input int max_hold,
                             input int rounds);
    int target;
    target = round_cnt + rounds;
    stop_traffic = 1'b0;
    fork
      drive_port(2'd0, count, max_gap, max_hold);
      drive_port(2'd1, count, max_gap, max_hold);
      drive_port(2'd2, count, max_gap, max_hold);
      drive_port(2'd3, count, max_gap, max_hold);
      begin
        if (rounds > 0) begin
          wait (round_cnt >= target);
          stop_traffic = 1'b1;
        end
      end
    join
  endtask

  // Scoreboard
  always @(negedge clk) begin
    port_vec_t exp_gnt;
    port_vec_t pick;
    port_idx_t pi;
    if (!rst_n) begin
      rr_hist  = '0;
      prev_gnt = '0;
      prev_ack = '0;
    end else begin
      if (gnt != '0 && prev_gnt == '0) begin
        exp_gnt = next_grant(prev_req, prev_mode, rr_hist, '0);
        if (prev_mode == MODE_RAND) begin
          // Any fixed scheme is a legal random pick
          for (int s = 1; s < NUM_PORTS; s++) begin
            pick = next_grant(prev_req, prev_mode, rr_hist, port_idx_t'(s));
            if (pick == gnt) begin
              exp_gnt = pick;
            end
          end
        end
        check_grant(gnt, exp_gnt, "grant");
        if (exp_gnt != '0) begin
          rr_hist = port_of(exp_gnt);
        end
        win_log.push_back(gnt);
        round_cnt++;
      end
      if ($countones(ack) > 1 || (ack & ~gnt) != '0) begin
        flag_protocol($sformatf("ack %b does not match grant %b", ack, gnt));
      end
      for (int i = 0; i < NUM_PORTS; i++) begin
        pi = port_idx_t'(i);
        if (ack[pi] && !prev_ack[pi]) begin
          if (we[pi]) begin
            mem_model[addr[pi]] = wdata[pi];
          end else begin
            check_data(rdata, mem_model[addr[pi]], "read data");
          end
        end
        if (prev_ack[pi] && !ack[pi] && prev_req[pi]) begin
          flag_protocol("ack fell while req was still high");
        end
      end
      prev_gnt = gnt;
      prev_ack = ack;
    end
    prev_req  = req;
    prev_mode = arb_mode;
  end

  initial begin
    addr_t ad;
    int    start;
    int    hits;
    rst_n        = 1'b0;
    req          = '0;
    we           = '0;
    addr         = '0;
    wdata        = '0;
    arb_mode     = MODE_P0;
    stop_traffic = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_grant(gnt, '0, "gnt after reset");
    check_grant(ack, '0, "ack after reset");

    // Pattern fill then read back by lone requesters on an idle controller
    for (int a = 0; a < MEM_DEPTH; a++) begin
      ad = addr_t'(a);
      do_txn(2'd0, 1'b1, ad, {~ad, ad}, 0, 1'b1);
    end
    for (int a = 0; a < MEM_DEPTH; a++) begin
      do_txn(2'd3, 1'b0, addr_t'(a), '0, 0, 1'b1);
    end

    for (int m = 0; m < 4; m++) begin
      @(posedge clk);
      arb_mode <= arb_mode_t'(m);
      run_traffic(5, 3, 2, 0);
    end

    // Round robin from a fresh history
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n    <= 1'b1;
    arb_mode <= MODE_RR;
    @(negedge clk);
    check_grant(gnt, '0, "gnt after reset");
    check_grant(ack, '0, "ack after reset");
    start = round_cnt;
    run_traffic(100, 0, 0, 8);
    for (int k = 0; k < 4; k++) begin
      check_grant(win_log[start + k], port_vec_t'(1) << ((k + 1) % NUM_PORTS),
                  "round robin winner");
    end
    run_traffic(6, 8, 1, 0);

    @(posedge clk);
    arb_mode <= MODE_RAND;
    start = round_cnt;
    run_traffic(100, 0, 0, 28);
    for (int p = 0; p < NUM_PORTS; p++) begin
      hits = 0;
      for (int k = 0; k < 28; k++) begin
        if ((win_log[start + k] & (port_vec_t'(1) << p)) != '0) begin
          hits++;
        end
      end
      if (hits == 0) begin
        flag_protocol($sformatf("port %0d never won in 28 random rounds", p));
      end
    end
    run_traffic(6, 3, 1, 0); // Sparse overlapping requests under random mode

    // Unused codes hold the request off until the mode changes
    for (int m = 6; m < 8; m++) begin
      @(posedge clk);
      arb_mode <= arb_mode_t'(m);
      fork
        do_txn(2'd2, 1'b0, addr_t'(m), '0, 0, 1'b0);
        begin
          repeat (40) begin
            @(negedge clk);
            if (ack != '0) begin
              flag_protocol("ack raised under an unused mode");
            end
          end
          @(posedge clk);
          arb_mode <= MODE_P0;
        end
      join
    end

    repeat (4) @(posedge clk);
    $display("Summary: %0d grant errors, %0d data errors, %0d protocol errors in %0d rounds",
             grant_errs, data_errs, proto_errs, round_cnt);
    if (grant_errs + data_errs + proto_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TXN_BUDGET * CYCLES_PER_TXN) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles",
             TXN_BUDGET * CYCLES_PER_TXN);
    $display("Something failed");
    $finish;
  end

endmodule

// File: list.f
+incdir+tests
logic/arb_pkg.sv
logic/mem_bus_if.sv
logic/pn_seq_gen.sv
logic/grant_arbiter.sv
logic/access_sequencer.sv
logic/shared_mem.sv
logic/arb_top.sv
tests/arb_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module arb_tb -f list.f
sim_out=$(./obj_dir/Varb_tb)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
